// ==== vlog.f ====
+incdir+hw
hw/tile_pkg.sv
hw/config_mem.sv
hw/pe_alu.sv
hw/pe_datapath.sv
hw/pe_controller.sv
hw/pe_tile.sv
bench/pe_tile_sva.sv
bench/pe_tile_tb.sv

// ==== Makefile ====
# Verilator build and run of the PE tile testbench

VERILATOR ?= verilator
TOP       ?= pe_tile_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Simulation completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(wildcard hw/*.sv hw/*.svh bench/*.sv)
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

test: $(SIM_BIN)
	@out=$$(./$(SIM_BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/pe_tile_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tile_config.svh"

module pe_tile_tb import tile_pkg::*; ();

  localparam int TILE_ID        = 5;
  localparam int OTHER_ID       = 11;
  // Longest program, in cycles without stalls
  localparam int MAX_STEPS      = 24;
  localparam int N_RUNS         = 5;
  // Reset, program, constants and spare writes per run
  localparam int LOAD_CYCLES    = 48;
  localparam int TIMEOUT_CYCLES = N_RUNS * (4 * MAX_STEPS + LOAD_CYCLES);

  logic                        Clk;
  logic                        Reset;
  logic                        dma_en_i;
  logic [`TILE_DMA_ADDR_W-1:0] dma_addr_i;
  logic [`TILE_DATA_W-1:0]     dma_data_i;
  logic [`TILE_ID_W-1:0]       tile_id_i;
  logic                        exec_start_i;
  logic                        end_exec_o;
  logic [`TILE_NB_PE-1:0]      cond_i;
  logic [`TILE_NB_PE-1:0]      stall_i;
  word_t                       pe_in_n_i;
  word_t                       pe_in_s_i;
  word_t                       pe_in_e_i;
  word_t                       pe_in_w_i;
  word_t                       pe_out_o;
  logic                        cond_o;
  logic [`TILE_CNT_W-1:0]      ins_count_o;
  logic [`TILE_CNT_W-1:0]      cycle_count_o;

  int    seed = 32'h61c43c5b;
  inst_t prog [`TILE_IM_DEPTH];
  word_t consts [`TILE_CRF_DEPTH];
  int    prog_len;
  int    const_len;
  // Expected values for the compare process
  word_t exp_result;
  logic  exp_flag;
  int    exp_ins;
  int    runs_done;
  word_t last_out;
  int    cycles;

  pe_tile u_dut (.*);

  always #4 Clk = ~Clk;

  ////////////////////////////////
  // Failure reporting
  ////////////////////////////////

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: time %0t signal %s got %h expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////
  // Instruction encoding
  ////////////////////////////////

  // Layout a1 c1 a0 c0 dst opcode
  function automatic inst_t alu_inst(input opcode_t op, input logic [2:0] dst,
                                     input logic c0, input logic [4:0] a0,
                                     input logic c1, input logic [4:0] a1);
    return {a1, c1, a0, c0, dst, op};
  endfunction

  function automatic inst_t nop_inst(input logic [4:0] cnt);
    return {10'b0, cnt, NOP};
  endfunction

  function automatic inst_t jmp_inst(input logic [5:0] tgt);
    return {9'b0, tgt, JMP};
  endfunction

  // Taken target low, fall-through target high
  function automatic inst_t br_inst(input logic [5:0] tgt, input logic [5:0] nt);
    return {3'b0, nt, tgt, BR};
  endfunction

  function automatic inst_t exit_inst();
    return {15'b0, EXIT};
  endfunction

  ////////////////////////////////
  // Reference model
  ////////////////////////////////

  // Constant, then neighbour code, else local register
  function automatic word_t operand_value(input logic is_const, input logic [4:0] addr,
                                          input word_t rf_word);
    if (is_const) return consts[addr];
    case (addr)
      5'h09:   return pe_in_n_i;
      5'h0A:   return pe_in_s_i;
      5'h0B:   return pe_in_e_i;
      5'h0C:   return pe_in_w_i;
      default: return rf_word;
    endcase
  endfunction

  // Runs prog from address 0 on a freshly reset tile
  function automatic void ref_run(output word_t res, output logic flag,
                                  output int count, output int steps);
    word_t      rf [8];
    logic [5:0] pc;
    inst_t      inst;
    opcode_t    op;
    word_t      a;
    word_t      b;
    word_t      r;
    logic       done;
    for (int i = 0; i < 8; i++) begin
      rf[i] = '0;
    end
    res   = '0;
    flag  = 1'b0;
    count = 0;
    steps = 0;
    pc    = '0;
    done  = 1'b0;
    while (!done && steps <= 4 * MAX_STEPS) begin
      inst = prog[pc];
      op   = opcode_t'(inst[5:0]);
      a    = operand_value(inst[9], inst[14:10], rf[inst[12:10]]);
      b    = operand_value(inst[15], inst[20:16], rf[inst[18:16]]);
      count++;
      steps++;
      case (op)
        // Count above 1 adds wait cycles
        NOP: begin
          if (inst[10:6] > 5'd1) steps += int'(inst[10:6]) - 1;
          pc++;
        end
        EXIT: done = 1'b1;
        JMP:  pc = inst[11:6];
        BR:   pc = (|cond_i) ? inst[11:6] : inst[17:12];
        ADD, SUB, AND, OR, XOR, SLT: begin
          case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            default: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          endcase
          rf[inst[8:6]] = r;
          res = r;
          if (op == SLT) flag = r[0];
          pc++;
        end
        default: pc++;
      endcase
    end
  endfunction

  ////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////

  task automatic apply_reset();
    @(negedge Clk);
    Reset = 1'b0;
    repeat (2) @(negedge Clk);
    Reset = 1'b1;
  endtask

  task automatic clear_program();
    for (int i = 0; i < `TILE_IM_DEPTH; i++) prog[i] = '0;
    for (int i = 0; i < `TILE_CRF_DEPTH; i++) consts[i] = '0;
  endtask

  task automatic dma_write(input int id_bit, input logic to_crf, input int waddr,
                           input logic [31:0] data);
    @(negedge Clk);
    dma_en_i = 1'b1;
    dma_addr_i = '0;
    dma_addr_i[id_bit] = 1'b1;
    dma_addr_i[`TILE_DMA_SEL_BIT] = to_crf;
    dma_addr_i[`TILE_DMA_ADDR_W-1:`TILE_DMA_WADDR_LSB] = waddr[5:0];
    dma_data_i = data;
  endtask

  // Corrupt mode writes EXIT and inverted constants instead
  task automatic load_tile(input int id_bit, input logic corrupt);
    for (int i = 0; i < prog_len; i++) begin
      dma_write(id_bit, 1'b0, i, {11'b0, corrupt ? exit_inst() : prog[i]});
    end
    for (int i = 0; i < const_len; i++) begin
      dma_write(id_bit, 1'b1, i, corrupt ? ~consts[i] : consts[i]);
    end
    @(negedge Clk);
    dma_en_i = 1'b0;
  endtask

  task automatic run_and_check(input logic use_stall);
    int n;
    int stalls;
    int steps;
    int rnd;
    ref_run(exp_result, exp_flag, exp_ins, steps);
    if (steps > MAX_STEPS) begin
      $display("Program takes %0d steps, more than the timeout allows", steps);
      stop_on_failure();
    end
    n = runs_done;
    stalls = 0;
    @(negedge Clk);
    exec_start_i = 1'b1;
    do begin
      @(negedge Clk);
      exec_start_i = 1'b0;
      rnd = $random(seed);
      // Random stall bit on about a quarter of the cycles
      if (use_stall && !end_exec_o && rnd[1:0] == 2'b00) begin
        stall_i = 16'h1 << rnd[7:4];
        stalls++;
      end else begin
        stall_i = '0;
      end
    end while (!end_exec_o);
    wait (runs_done == n + 1);
    if (cycle_count_o < steps + stalls) begin
      $display("cycle_count_o is %0d, below %0d run and stall cycles", cycle_count_o,
               steps + stalls);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////
  // Compare process and timeout
  ////////////////////////////////

  // Last word seen while exec was high holds the result
  always @(negedge Clk) begin
    if (end_exec_o) begin
      check("pe_out_o", last_out, exp_result);
      // Exec already low, output forced to zero
      check("pe_out_o", pe_out_o, 32'h0);
      check("cond_o", {31'b0, cond_o}, {31'b0, exp_flag});
      check("ins_count_o", ins_count_o, exp_ins);
      runs_done = runs_done + 1;
    end else begin
      last_out = pe_out_o;
    end
  end

  always @(posedge Clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles without the end of the run", cycles);
      stop_on_failure();
    end
  end

  initial begin
    Clk = 1'b0;
    Reset = 1'b0;
    dma_en_i = 1'b0;
    dma_addr_i = '0;
    dma_data_i = '0;
    tile_id_i = TILE_ID;
    exec_start_i = 1'b0;
    cond_i = '0;
    stall_i = '0;
    pe_in_n_i = 32'h0000_1234;
    pe_in_s_i = 32'hA5A5_F00F;
    pe_in_e_i = 32'h0003_0000;
    pe_in_w_i = 32'h8000_0011;
    runs_done = 0;
    last_out = '0;
    cycles = 0;

    // Writes for another tile id must not land
    clear_program();
    consts[0] = 32'h0000_0040;
    consts[1] = 32'h0000_0003;
    prog[0] = alu_inst(ADD, 3'd1, 1'b1, 5'd0, 1'b1, 5'd1);
    prog[1] = alu_inst(SUB, 3'd2, 1'b0, 5'd1, 1'b1, 5'd1);
    prog[2] = alu_inst(XOR, 3'd3, 1'b0, 5'd2, 1'b0, 5'd1);
    prog[3] = exit_inst();
    prog_len = 4;
    const_len = 2;
    apply_reset();
    load_tile(TILE_ID, 1'b0);
    load_tile(OTHER_ID, 1'b1);
    run_and_check(1'b0);

    // All ALU operations, constants, registers and neighbours
    clear_program();
    consts[0] = 32'd100;
    consts[1] = 32'hFFFF_FFF9;
    consts[2] = 32'h0F0F_00FF;
    prog[0] = alu_inst(ADD, 3'd1, 1'b1, 5'd0, 1'b0, SRC_N);
    prog[1] = alu_inst(SUB, 3'd2, 1'b0, 5'd1, 1'b1, 5'd1);
    prog[2] = alu_inst(AND, 3'd3, 1'b0, SRC_S, 1'b1, 5'd2);
    prog[3] = alu_inst(OR, 3'd4, 1'b0, SRC_E, 1'b0, 5'd3);
    prog[4] = alu_inst(XOR, 3'd5, 1'b0, SRC_W, 1'b0, 5'd2);
    prog[5] = alu_inst(SLT, 3'd6, 1'b0, 5'd5, 1'b1, 5'd1);
    prog[6] = alu_inst(ADD, 3'd7, 1'b0, 5'd4, 1'b0, 5'd5);
    prog[7] = alu_inst(XOR, 3'd0, 1'b0, 5'd7, 1'b0, 5'd6);
    prog[8] = exit_inst();
    prog_len = 9;
    const_len = 3;
    apply_reset();
    load_tile(TILE_ID, 1'b0);
    run_and_check(1'b0);

    // Branch both ways, JMP over a visible OR
    clear_program();
    consts[0] = 32'd5;
    consts[1] = 32'd3;
    consts[2] = 32'h0000_0F00;
    prog[0] = alu_inst(ADD, 3'd1, 1'b1, 5'd0, 1'b1, 5'd1);
    prog[1] = br_inst(6'd6, 6'd2);
    prog[2] = alu_inst(SUB, 3'd2, 1'b0, 5'd1, 1'b1, 5'd1);
    prog[3] = jmp_inst(6'd5);
    prog[4] = alu_inst(OR, 3'd3, 1'b1, 5'd2, 1'b1, 5'd2);
    prog[5] = exit_inst();
    prog[6] = alu_inst(XOR, 3'd2, 1'b0, 5'd1, 1'b1, 5'd0);
    prog[7] = exit_inst();
    prog_len = 8;
    const_len = 3;
    for (int pass = 0; pass < 2; pass++) begin
      cond_i = (pass == 0) ? 16'h0000 : 16'h0040;
      apply_reset();
      load_tile(TILE_ID, 1'b0);
      run_and_check(1'b0);
    end
    cond_i = '0;

    // Long NOP under random stalls
    clear_program();
    consts[0] = 32'd7;
    consts[1] = 32'd2;
    prog[0] = alu_inst(ADD, 3'd1, 1'b1, 5'd0, 1'b0, SRC_W);
    prog[1] = nop_inst(5'd5);
    prog[2] = alu_inst(SUB, 3'd2, 1'b0, 5'd1, 1'b1, 5'd1);
    prog[3] = alu_inst(SLT, 3'd3, 1'b0, 5'd2, 1'b1, 5'd0);
    prog[4] = exit_inst();
    prog_len = 5;
    const_len = 2;
    apply_reset();
    load_tile(TILE_ID, 1'b0);
    run_and_check(1'b1);

    @(negedge Clk);
    if (u_dut.u_ctrl.u_sva.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("%0d assertion failures in the controller", u_dut.u_ctrl.u_sva.fail_count);
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

// ==== bench/pe_tile_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tile_config.svh"

module pe_tile_sva import tile_pkg::*; (
  input logic                   Clk,
  input logic                   Reset,
  input logic [`TILE_NB_PE-1:0] stall_i,
  input inst_addr_t             inst_addr_o,
  input logic                   exec_o,
  input logic                   end_exec_o
);

  // Failed assertions, read back by the testbench
  int fail_count = 0;

  // End pulse lasts a single cycle
  a_end_single: assert property (@(posedge Clk) disable iff (!Reset)
    end_exec_o |=> !end_exec_o)
    else begin
      $error("end_exec_o high for two cycles");
      fail_count++;
    end

  // Idle tile in and right out of reset
  a_reset_idle: assert property (@(posedge Clk)
    (!Reset || $rose(Reset)) |-> (!exec_o && !end_exec_o && inst_addr_o == '0))
    else begin
      $error("controller not idle after reset");
      fail_count++;
    end

  // Any stall bit freezes the sequencer
  a_stall_hold: assert property (@(posedge Clk) disable iff (!Reset)
    (|stall_i) |=> $stable(inst_addr_o))
    else begin
      $error("instruction address moved during stall");
      fail_count++;
    end

endmodule

bind pe_controller pe_tile_sva u_sva (
  .Clk         (Clk),
  .Reset       (Reset),
  .stall_i     (stall_i),
  .inst_addr_o (inst_addr_o),
  .exec_o      (exec_o),
  .end_exec_o  (end_exec_o)
);

`default_nettype wire

// ==== hw/pe_tile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tile_config.svh"

module pe_tile import tile_pkg::*; (
  input  logic                        Clk,
  input  logic                        Reset,
  // DMA configuration port
  input  logic                        dma_en_i,
  input  logic [`TILE_DMA_ADDR_W-1:0] dma_addr_i,
  input  logic [`TILE_DATA_W-1:0]     dma_data_i,
  input  logic [`TILE_ID_W-1:0]       tile_id_i,
  // Run control
  input  logic                        exec_start_i,
  output logic                        end_exec_o,
  input  logic [`TILE_NB_PE-1:0]      cond_i,
  input  logic [`TILE_NB_PE-1:0]      stall_i,
  // Neighbour words
  input  word_t                       pe_in_n_i,
  input  word_t                       pe_in_s_i,
  input  word_t                       pe_in_e_i,
  input  word_t                       pe_in_w_i,
  output word_t                       pe_out_o,
  output logic                        cond_o,
  output logic [`TILE_CNT_W-1:0]      ins_count_o,
  output logic [`TILE_CNT_W-1:0]      cycle_count_o
);

  logic       dma_hit;
  logic       imem_we;
  logic       crf_we;
  inst_addr_t imem_waddr;
  src_sel_t   crf_waddr;
  inst_addr_t inst_addr;
  inst_t      inst;
  logic       exec;
  logic       run_en;
  src_sel_t   crf_raddr0;
  src_sel_t   crf_raddr1;
  word_t      crf_rdata0;
  word_t      crf_rdata1;

  //////////////////////////////
  // DMA write decode
  //////////////////////////////

  // Address bit at tile_id marks this tile as a target
  assign dma_hit = dma_en_i & dma_addr_i[tile_id_i];
  assign imem_we = dma_hit & ~dma_addr_i[`TILE_DMA_SEL_BIT];
  assign crf_we  = dma_hit & dma_addr_i[`TILE_DMA_SEL_BIT];

  assign imem_waddr = dma_addr_i[`TILE_DMA_WADDR_LSB +: $bits(inst_addr_t)];
  assign crf_waddr  = dma_addr_i[`TILE_DMA_WADDR_LSB +: $bits(src_sel_t)];

  // Program store, second port unused
  config_mem #(.payload_t(inst_t), .DEPTH(`TILE_IM_DEPTH)) u_imem (
    .Clk      (Clk),
    .Reset    (Reset),
    .we_i     (imem_we),
    .waddr_i  (imem_waddr),
    .wdata_i  (dma_data_i[`TILE_INST_W-1:0]),
    .raddr0_i (inst_addr),
    .rdata0_o (inst),
    .raddr1_i ('0),
    .rdata1_o ()
  );

  // Constants, one port per operand
  config_mem #(.payload_t(word_t), .DEPTH(`TILE_CRF_DEPTH)) u_crf (
    .Clk      (Clk),
    .Reset    (Reset),
    .we_i     (crf_we),
    .waddr_i  (crf_waddr),
    .wdata_i  (dma_data_i),
    .raddr0_i (crf_raddr0),
    .rdata0_o (crf_rdata0),
    .raddr1_i (crf_raddr1),
    .rdata1_o (crf_rdata1)
  );

  pe_controller u_ctrl (
    .Clk           (Clk),
    .Reset         (Reset),
    .exec_start_i  (exec_start_i),
    .cond_i        (cond_i),
    .stall_i       (stall_i),
    .inst_i        (inst),
    .inst_addr_o   (inst_addr),
    .exec_o        (exec),
    .run_en_o      (run_en),
    .end_exec_o    (end_exec_o),
    .ins_count_o   (ins_count_o),
    .cycle_count_o (cycle_count_o)
  );

  pe_datapath u_dp (
    .Clk          (Clk),
    .Reset        (Reset),
    .exec_i       (exec),
    .run_en_i     (run_en),
    .inst_i       (inst),
    .crf_raddr0_o (crf_raddr0),
    .crf_raddr1_o (crf_raddr1),
    .crf_rdata0_i (crf_rdata0),
    .crf_rdata1_i (crf_rdata1),
    .pe_in_n_i    (pe_in_n_i),
    .pe_in_s_i    (pe_in_s_i),
    .pe_in_e_i    (pe_in_e_i),
    .pe_in_w_i    (pe_in_w_i),
    .pe_out_o     (pe_out_o),
    .cond_o       (cond_o)
  );

endmodule

`default_nettype wire

// ==== hw/pe_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tile_config.svh"

module pe_controller import tile_pkg::*; (
  input  logic                   Clk,
  input  logic                   Reset,
  input  logic                   exec_start_i,
  input  logic [`TILE_NB_PE-1:0] cond_i,
  input  logic [`TILE_NB_PE-1:0] stall_i,
  input  inst_t                  inst_i,
  output inst_addr_t             inst_addr_o,
  output logic                   exec_o,
  output logic                   run_en_o,
  output logic                   end_exec_o,
  output logic [`TILE_CNT_W-1:0] ins_count_o,
  output logic [`TILE_CNT_W-1:0] cycle_count_o
);

  opcode_t                opcode;
  logic                   global_cond;
  logic                   global_stall;
  logic                   nop_wait;
  logic                   exit_issue;
  logic                   nop_multi;
  logic [NOP_CNT_W-1:0]   nop_len;
  logic [NOP_CNT_W-1:0]   nop_cnt_q;
  inst_addr_t             addr_q;
  inst_addr_t             addr_inc;
  inst_addr_t             addr_next;
  logic                   exec_q;
  logic                   end_q;
  logic [`TILE_CNT_W-1:0] ins_cnt_q;
  logic [`TILE_CNT_W-1:0] cyc_cnt_q;

  //////////////////////////////
  // Array-wide OR
  //////////////////////////////

  // Any PE raising cond takes the branch
  assign global_cond  = |cond_i;
  // Any PE stalling freezes every tile
  assign global_stall = |stall_i;

  assign opcode  = opcode_t'(inst_i[OPC_MSB:OPC_LSB]);
  assign nop_len = inst_i[NOP_CNT_MSB:NOP_CNT_LSB];

  // Count still running from a long NOP
  assign nop_wait = (nop_cnt_q != '0);
  // One instruction issues per enabled cycle
  assign run_en_o = exec_q & ~global_stall & ~nop_wait;

  assign exit_issue = run_en_o && (opcode == EXIT);
  // NOP of one cycle behaves like any other step
  assign nop_multi  = (opcode == NOP) && (nop_len > NOP_CNT_W'(1));

  //////////////////////////////
  // Address sequencer
  //////////////////////////////

  assign addr_inc = addr_q + 1'b1;

  always_comb begin
    case (opcode)
      EXIT:    addr_next = '0;
      JMP:     addr_next = inst_i[TGT_T_MSB:TGT_T_LSB];
      // Taken and fall-through targets both encoded
      BR:      addr_next = global_cond ? inst_i[TGT_T_MSB:TGT_T_LSB]
                                       : inst_i[TGT_NT_MSB:TGT_NT_LSB];
      default: addr_next = addr_inc;
    endcase
  end

  // Stall freezes address and NOP count alike
  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      addr_q    <= '0;
      nop_cnt_q <= '0;
    end else if (!global_stall) begin
      if (run_en_o) begin
        if (nop_multi) begin
          // Hold for count-1 more cycles
          nop_cnt_q <= nop_len - 1'b1;
        end else begin
          addr_q <= addr_next;
        end
      end else if (nop_wait) begin
        nop_cnt_q <= nop_cnt_q - 1'b1;
        // Last wait cycle moves on
        if (nop_cnt_q == NOP_CNT_W'(1)) begin
          addr_q <= addr_inc;
        end
      end
    end
  end

  //////////////////////////////
  // Execute flag, end pulse
  //////////////////////////////

  // Start sets, issued EXIT clears; end follows the clearing edge
  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      exec_q <= 1'b0;
      end_q  <= 1'b0;
    end else begin
      end_q <= exit_issue;
      if (exec_start_i) begin
        exec_q <= 1'b1;
      end else if (exit_issue) begin
        exec_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Performance counters
  //////////////////////////////

  // Issued instructions, and all cycles in exec including stalls
  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      ins_cnt_q <= '0;
      cyc_cnt_q <= '0;
    end else begin
      if (run_en_o) begin
        ins_cnt_q <= ins_cnt_q + 1'b1;
      end
      if (exec_q) begin
        cyc_cnt_q <= cyc_cnt_q + 1'b1;
      end
    end
  end

  assign inst_addr_o   = addr_q;
  assign exec_o        = exec_q;
  assign end_exec_o    = end_q;
  assign ins_count_o   = ins_cnt_q;
  assign cycle_count_o = cyc_cnt_q;

endmodule

`default_nettype wire

// ==== hw/pe_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tile_config.svh"

module pe_datapath import tile_pkg::*; (
  input  logic     Clk,
  input  logic     Reset,
  input  logic     exec_i,
  input  logic     run_en_i,
  input  inst_t    inst_i,
  // CRF read ports
  output src_sel_t crf_raddr0_o,
  output src_sel_t crf_raddr1_o,
  input  word_t    crf_rdata0_i,
  input  word_t    crf_rdata1_i,
  // Neighbour words
  input  word_t    pe_in_n_i,
  input  word_t    pe_in_s_i,
  input  word_t    pe_in_e_i,
  input  word_t    pe_in_w_i,
  output word_t    pe_out_o,
  output logic     cond_o
);

  localparam int RF_AW = $clog2(`TILE_RF_DEPTH);

  opcode_t                  opcode;
  logic                     op0_const;
  logic                     op1_const;
  src_sel_t                 op0_addr;
  src_sel_t                 op1_addr;
  logic [DST_MSB-DST_LSB:0] dst;
  logic                     alu_op;
  word_t                    rf_q [`TILE_RF_DEPTH];
  word_t                    operand_a;
  word_t                    operand_b;
  word_t                    alu_result;
  logic                     alu_flag;
  word_t                    result_q;
  logic                     cond_q;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign opcode    = opcode_t'(inst_i[OPC_MSB:OPC_LSB]);
  assign dst       = inst_i[DST_MSB:DST_LSB];
  assign op0_const = inst_i[OP0_CONST_BIT];
  assign op1_const = inst_i[OP1_CONST_BIT];
  assign op0_addr  = inst_i[OP0_ADDR_MSB:OP0_ADDR_LSB];
  assign op1_addr  = inst_i[OP1_ADDR_MSB:OP1_ADDR_LSB];

  // Only the six ALU opcodes touch RF and result
  assign alu_op = opcode inside {ADD, SUB, AND, OR, XOR, SLT};

  // CRF addressed straight from the instruction
  assign crf_raddr0_o = op0_addr;
  assign crf_raddr1_o = op1_addr;

  //////////////////////////////
  // Operand select
  //////////////////////////////

  // Constant first, then neighbour codes, else local RF
  function automatic word_t select_operand(input logic     is_const,
                                           input src_sel_t addr,
                                           input word_t    crf_word,
                                           input word_t    rf_word);
    word_t sel;
    if (is_const) begin
      sel = crf_word;
    end else begin
      case (addr)
        SRC_N:   sel = pe_in_n_i;
        SRC_S:   sel = pe_in_s_i;
        SRC_E:   sel = pe_in_e_i;
        SRC_W:   sel = pe_in_w_i;
        default: sel = rf_word;
      endcase
    end
    return sel;
  endfunction

  assign operand_a = select_operand(op0_const, op0_addr, crf_rdata0_i,
                                    rf_q[op0_addr[RF_AW-1:0]]);
  assign operand_b = select_operand(op1_const, op1_addr, crf_rdata1_i,
                                    rf_q[op1_addr[RF_AW-1:0]]);

  pe_alu u_alu (
    .op_i     (opcode),
    .a_i      (operand_a),
    .b_i      (operand_b),
    .result_o (alu_result),
    .flag_o   (alu_flag)
  );

  //////////////////////////////
  // State update
  //////////////////////////////

  // RF, result and flag update at the end of the issue cycle
  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      for (int i = 0; i < `TILE_RF_DEPTH; i++) begin
        rf_q[i] <= '0;
      end
      result_q <= '0;
      cond_q   <= 1'b0;
    end else if (run_en_i && alu_op) begin
      rf_q[dst] <= alu_result;
      result_q  <= alu_result;
      // Flag follows SLT only
      if (opcode == SLT) begin
        cond_q <= alu_flag;
      end
    end
  end

  // Idle tile drives zero to its neighbours
  assign pe_out_o = exec_i ? result_q : '0;
  assign cond_o   = cond_q;

endmodule

`default_nettype wire

// ==== hw/pe_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module pe_alu import tile_pkg::*; (
  input  opcode_t op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   result_o,
  output logic    flag_o
);

  // Signed less-than, shared by SLT and the flag
  logic lt;

  assign lt = $signed(a_i) < $signed(b_i);

  // Compare flag for the cond register
  assign flag_o = lt;

  //////////////////////////////
  // Integer operations
  //////////////////////////////

  always_comb begin
    case (op_i)
      ADD: begin
        result_o = a_i + b_i;
      end
      SUB: begin
        result_o = a_i - b_i;
      end
      AND: begin
        result_o = a_i & b_i;
      end
      OR: begin
        result_o = a_i | b_i;
      end
      XOR: begin
        result_o = a_i ^ b_i;
      end
      // 1 or 0 in a full word
      SLT: begin
        result_o = {{($bits(word_t)-1){1'b0}}, lt};
      end
      // Control and unknown opcodes
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/config_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module config_mem import tile_pkg::*; #(
  parameter type payload_t = word_t,
  parameter int  DEPTH     = 32
) (
  input  logic                     Clk,
  input  logic                     Reset,
  // DMA write port
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  payload_t                 wdata_i,
  // Two combinational read ports
  input  logic [$clog2(DEPTH)-1:0] raddr0_i,
  output payload_t                 rdata0_o,
  input  logic [$clog2(DEPTH)-1:0] raddr1_i,
  output payload_t                 rdata1_o
);

  // Storage
  payload_t mem_q [DEPTH];

  //////////////////////////////
  // Write side
  //////////////////////////////

  // Whole array cleared on reset, then loaded word by word
  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  // Same-cycle reads, no output register
  assign rdata0_o = mem_q[raddr0_i];
  assign rdata1_o = mem_q[raddr1_i];

endmodule

`default_nettype wire

// ==== hw/tile_pkg.sv ====
`default_nettype none

`include "tile_config.svh"

package tile_pkg;

  //////////////////////////////
  // Basic words
  //////////////////////////////

  typedef logic [`TILE_DATA_W-1:0] word_t;
  typedef logic [`TILE_INST_W-1:0] inst_t;
  // Instruction memory address
  typedef logic [$clog2(`TILE_IM_DEPTH)-1:0] inst_addr_t;
  // Operand address, CRF index or RF / neighbour code
  typedef logic [4:0] src_sel_t;

  // Opcode encoding
  typedef enum logic [5:0] {
    NOP  = 6'h00,
    ADD  = 6'h01,
    SUB  = 6'h02,
    AND  = 6'h03,
    OR   = 6'h04,
    XOR  = 6'h05,
    SLT  = 6'h06,
    BR   = 6'h13,
    JMP  = 6'h14,
    EXIT = 6'h1F
  } opcode_t;

  // Neighbour source codes
  localparam src_sel_t SRC_N = 5'h09;
  localparam src_sel_t SRC_S = 5'h0A;
  localparam src_sel_t SRC_E = 5'h0B;
  localparam src_sel_t SRC_W = 5'h0C;

  //////////////////////////////
  // Instruction fields
  //////////////////////////////

  localparam int OPC_LSB       = 0;
  localparam int OPC_MSB       = 5;
  localparam int DST_LSB       = 6;
  localparam int DST_MSB       = 8;
  localparam int OP0_CONST_BIT = 9;
  localparam int OP0_ADDR_LSB  = 10;
  localparam int OP0_ADDR_MSB  = 14;
  localparam int OP1_CONST_BIT = 15;
  localparam int OP1_ADDR_LSB  = 16;
  localparam int OP1_ADDR_MSB  = 20;
  // NOP count overlays dst and part of op0
  localparam int NOP_CNT_LSB   = 6;
  localparam int NOP_CNT_MSB   = 10;
  localparam int NOP_CNT_W     = NOP_CNT_MSB - NOP_CNT_LSB + 1;
  // JMP and taken BR target
  localparam int TGT_T_LSB     = 6;
  localparam int TGT_T_MSB     = 11;
  // Not-taken BR target
  localparam int TGT_NT_LSB    = 12;
  localparam int TGT_NT_MSB    = 17;

endpackage

`default_nettype wire

// ==== hw/tile_config.svh ====
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

//////////////////////////////
// Array geometry
//////////////////////////////

// PEs in the array, one cond and one stall bit each
`define TILE_NB_PE 16
// Tile id selects one DMA address bit
`define TILE_ID_W 4

//////////////////////////////
// Datapath widths
//////////////////////////////

`define TILE_DATA_W 32
`define TILE_INST_W 21
// Performance counters
`define TILE_CNT_W 32

//////////////////////////////
// Memory depths
//////////////////////////////

// Instruction memory, 6-bit address
`define TILE_IM_DEPTH 64
// Constant register file, 5-bit address
`define TILE_CRF_DEPTH 32
// Local register file
`define TILE_RF_DEPTH 8

//////////////////////////////
// DMA address fields
//////////////////////////////

`define TILE_DMA_ADDR_W 23
// 1 selects the CRF, 0 the instruction memory
`define TILE_DMA_SEL_BIT 16
// Write address starts here
`define TILE_DMA_WADDR_LSB 17

`endif
